/* verilog/btiger_pkg.sv */
// SDRAM is 16-bit word addressed; slot widths and PROM count are fixed here for this board only
package btiger_pkg;

    localparam int SDRAM_AW   = 22; // SDRAM word address
    localparam int CHAR_AW    = 14;
    localparam int OBJ_AW     = 17;
    localparam int SLOT_AW    = (OBJ_AW > CHAR_AW) ? OBJ_AW : CHAR_AW;
    localparam int PROM_COUNT = 5;
    localparam int PROM_SEL_W = 3;
    localparam int PROM_IDX_W = 8;

    // Raster position and the strobes decoded from it
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       lhbl;   // Low in horizontal blank
        logic       lvbl;   // Low in vertical blank
        logic       hs;
        logic       vs;
        logic       hinit;  // One clock at line start
    } video_timing_t;

    // Programming address, read one of two ways depending on the target
    typedef union packed {
        logic [SDRAM_AW-1:0] sdram;
        struct packed {
            logic [SDRAM_AW-PROM_SEL_W-PROM_IDX_W-1:0] spare;
            logic [PROM_SEL_W-1:0]                     sel;   // Which PROM
            logic [PROM_IDX_W-1:0]                     index; // Entry in that PROM
        } prom;
    } prog_addr_u;

    typedef struct packed {
        prog_addr_u addr;
        logic [7:0] data;
        logic [1:0] mask;   // Active low, one bit per byte lane
        logic       we;     // Held until sdram_ack
    } prog_bus_t;

    // Request from a graphics layer, sized for the wider slot
    typedef struct packed {
        logic               cs;
        logic [SLOT_AW-1:0] addr;
    } slot_req_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } slot_rsp_t;

endpackage

/* verilog/cen_gen.sv */
// Expects a 48 MHz clk; enables are single-cycle pulses, first cen6 eight clocks after reset
module cen_gen (
    input  logic clk,
    input  logic reset,
    output logic cen12,
    output logic cen6,
    output logic cen3
);

    logic [3:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= 4'd0;
        end else begin
            cnt <= cnt + 4'd1;
        end
    end

    // Each slower enable lands on a faster one
    assign cen12 = &cnt[1:0];   // 48 / 4
    assign cen6  = &cnt[2:0];   // 48 / 8
    assign cen3  = &cnt;        // 48 / 16

    // Slower enables must nest inside the faster ones
    cen3_nested: assert property (
        @(posedge clk) disable iff (reset)
        cen3 |-> cen6 && cen12
    );

endmodule

/* verilog/video_timer.sv */
// Advances on cen6 only; sync windows wrap modulo the totals, so rasters under 32 pixels keep hs high
module video_timer #(
    parameter int H_TOTAL   = 384,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 262,
    parameter int V_VISIBLE = 224
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cen6,
    output btiger_pkg::video_timing_t timing
);

    localparam int HS_LEN   = 32;
    localparam int VS_LEN   = 4;
    localparam int HS_START = (H_VISIBLE + 16) % H_TOTAL;
    localparam int VS_START = (V_VISIBLE + 8) % V_TOTAL;

    logic       h_wrap;
    logic [8:0] h_next;
    logic [8:0] v_next;
    logic [9:0] h_rel;  // Pixels past the start of horizontal sync
    logic [9:0] v_rel;  // Lines past the start of vertical sync

    always_comb begin
        h_wrap = timing.h == 9'(H_TOTAL - 1);
        h_next = h_wrap ? 9'd0 : timing.h + 9'd1;
        v_next = timing.v;
        if (h_wrap) begin
            v_next = (timing.v == 9'(V_TOTAL - 1)) ? 9'd0 : timing.v + 9'd1;
        end

        // Distance into the sync window, taken around the end of line
        if (h_next >= 9'(HS_START)) begin
            h_rel = {1'b0, h_next} - 10'(HS_START);
        end else begin
            h_rel = {1'b0, h_next} + 10'(H_TOTAL - HS_START);
        end
        if (v_next >= 9'(VS_START)) begin
            v_rel = {1'b0, v_next} - 10'(VS_START);
        end else begin
            v_rel = {1'b0, v_next} + 10'(V_TOTAL - VS_START);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timing.h     <= 9'd0;
            timing.v     <= 9'd0;
            timing.lhbl  <= 1'b1;   // Position 0 is visible
            timing.lvbl  <= 1'b1;
            timing.hs    <= 1'b0;
            timing.vs    <= 1'b0;
            timing.hinit <= 1'b0;
        end else begin
            timing.hinit <= 1'b0;
            if (cen6) begin
                timing.h     <= h_next;
                timing.v     <= v_next;
                timing.lhbl  <= h_next < 9'(H_VISIBLE);
                timing.lvbl  <= v_next < 9'(V_VISIBLE);
                timing.hs    <= h_rel < 10'(HS_LEN);
                timing.vs    <= v_rel < 10'(VS_LEN);
                timing.hinit <= h_wrap;     // Same clock as h returns to 0
            end
        end
    end

    h_in_range: assert property (
        @(posedge clk) disable iff (reset)
        timing.h < 9'(H_TOTAL)
    );

    v_in_range: assert property (
        @(posedge clk) disable iff (reset)
        timing.v < 9'(V_TOTAL)
    );

endmodule

/* verilog/prom_loader.sv */
// Byte stream below PROM_START goes to SDRAM; the host must wait for sdram_ack between SDRAM bytes
module prom_loader #(
    parameter logic [21:0] PROM_START = 22'h1C_0000
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 downloading,
    input  logic                                 ioctl_wr,
    input  logic                                 sdram_ack,
    input  logic [21:0]                          ioctl_addr,
    input  logic [7:0]                           ioctl_dout,
    output btiger_pkg::prog_bus_t                prog,
    output logic [btiger_pkg::PROM_COUNT-1:0]    prom_we
);

    import btiger_pkg::*;

    prog_addr_u  addr_q;
    logic [7:0]  data_q;
    logic [1:0]  mask_q;
    logic        we_q;
    logic        wr_in;
    logic        is_prom;
    logic [21:0] prom_off;  // Byte offset inside the PROM area

    assign wr_in    = downloading && ioctl_wr;
    assign is_prom  = ioctl_addr >= PROM_START;
    assign prom_off = ioctl_addr - PROM_START;

    always_ff @(posedge clk) begin
        if (reset) begin
            we_q    <= 1'b0;
            prom_we <= '0;
        end else begin
            prom_we <= '0;
            if (wr_in && !is_prom) begin
                we_q <= 1'b1;
            end else if (sdram_ack) begin
                we_q <= 1'b0;
            end
            if (wr_in && is_prom) begin
                prom_we <= PROM_COUNT'(1) << prom_off[10:8];  // 256 entries per PROM
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_in) begin
            data_q <= ioctl_dout;
            if (is_prom) begin
                addr_q.prom.spare <= '0;
                addr_q.prom.sel   <= prom_off[10:8];
                addr_q.prom.index <= prom_off[7:0];
                mask_q            <= 2'b11;     // No lane, SDRAM is idle
            end else begin
                addr_q.sdram <= {1'b0, ioctl_addr[21:1]};
                // Even byte in the low lane
                mask_q       <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

    assign prog = '{addr: addr_q, data: data_q, mask: mask_q, we: we_q};

    prom_we_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(prom_we)
    );

    // Host paces bytes on the SDRAM acknowledge
    no_write_while_pending: assert property (
        @(posedge clk) disable iff (reset)
        wr_in |-> !we_q
    );

endmodule

/* verilog/rom_fetch_fsm.sv */
// Two slots with one cached word each; requesters must hold addr while cs is high and ok is low
module rom_fetch_fsm #(
    parameter logic [btiger_pkg::SDRAM_AW-1:0] CHAR_OFFSET = 22'h02_8000,
    parameter logic [btiger_pkg::SDRAM_AW-1:0] OBJ_OFFSET  = 22'h0A_0000
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            downloading,
    input  logic                            lvbl,
    input  logic                            sdram_ack,
    input  logic                            data_rdy,
    input  btiger_pkg::slot_req_t           char_req,
    input  btiger_pkg::slot_req_t           obj_req,
    input  logic [15:0]                     data_read,
    output btiger_pkg::slot_rsp_t           char_rsp,
    output btiger_pkg::slot_rsp_t           obj_rsp,
    output logic                            sdram_req,
    output logic [btiger_pkg::SDRAM_AW-1:0] sdram_addr
);

    import btiger_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_t;

    state_t              state;
    logic                sel;        // Slot in flight, 0 char and 1 obj
    logic                prio;       // Preferred slot on a tie
    logic                grant;
    logic [1:0]          req_cs;
    logic [1:0]          hit;
    logic [1:0]          miss;
    logic [1:0]          valid;
    logic [OBJ_AW-1:0]   req_addr   [2];
    logic [OBJ_AW-1:0]   cache_addr [2];
    logic [15:0]         cache_data [2];
    logic [OBJ_AW-1:0]   fetch_addr;
    logic [SDRAM_AW-1:0] fetch_base;

    assign req_cs      = {obj_req.cs, char_req.cs};
    assign req_addr[0] = OBJ_AW'(char_req.addr[CHAR_AW-1:0]);
    assign req_addr[1] = obj_req.addr[OBJ_AW-1:0];

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i] = req_cs[i] && valid[i] && cache_addr[i] == req_addr[i];
        end
        miss[0] = req_cs[0] && !hit[0] && lvbl;    // Char layer fetches only in active lines
        miss[1] = req_cs[1] && !hit[1];
        grant   = (miss[0] && (!miss[1] || !prio)) ? 1'b0 : 1'b1;
    end

    assign fetch_base = grant ? OBJ_OFFSET : CHAR_OFFSET;

    // Hits answer in the same clock
    assign char_rsp = '{ok: hit[0], data: cache_data[0]};
    assign obj_rsp  = '{ok: hit[1], data: cache_data[1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            sel       <= 1'b0;
            prio      <= 1'b0;     // Char wins the first tie
            valid     <= 2'b00;
        end else begin
            case (state)
                IDLE: begin
                    if (!downloading && |miss) begin
                        sel       <= grant;
                        prio      <= !grant;
                        sdram_req <= 1'b1;
                        state     <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        valid[sel] <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // New ROM contents make both cached words stale
            if (downloading) begin
                valid <= 2'b00;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            fetch_addr <= req_addr[grant];
            sdram_addr <= fetch_base + SDRAM_AW'(req_addr[grant]);
        end
        if (state == WAIT_DATA && data_rdy) begin
            cache_data[sel] <= data_read;
            cache_addr[sel] <= fetch_addr;
        end
    end

    sdram_addr_held: assert property (
        @(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr)
    );

    // SDRAM side may only return data for a read in flight
    rdy_only_when_waiting: assert property (
        @(posedge clk) disable iff (reset)
        data_rdy |-> state == WAIT_DATA
    );

endmodule

/* verilog/btiger_game.sv */
// Memory loading and timing core only; CPUs, renderers and sound sit outside on the slot ports
module btiger_game #(
    parameter int                              H_TOTAL     = 384,
    parameter int                              H_VISIBLE   = 256,
    parameter int                              V_TOTAL     = 262,
    parameter int                              V_VISIBLE   = 224,
    parameter logic [21:0]                     PROM_START  = 22'h1C_0000,
    parameter logic [btiger_pkg::SDRAM_AW-1:0] CHAR_OFFSET = 22'h02_8000,
    parameter logic [btiger_pkg::SDRAM_AW-1:0] OBJ_OFFSET  = 22'h0A_0000
) (
    input  logic                              clk,
    input  logic                              reset,
    // Download
    input  logic                              downloading,
    input  logic                              ioctl_wr,
    input  logic [21:0]                       ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    // SDRAM
    input  logic                              sdram_ack,
    input  logic                              data_rdy,
    input  logic [15:0]                       data_read,
    // Graphics slots
    input  btiger_pkg::slot_req_t             char_req,
    input  btiger_pkg::slot_req_t             obj_req,
    output logic                              pxl2_cen,   // 12 MHz
    output logic                              pxl_cen,    // 6 MHz
    output btiger_pkg::video_timing_t         timing,
    output logic                              dwnld_busy,
    output btiger_pkg::prog_bus_t             prog,
    output logic [btiger_pkg::PROM_COUNT-1:0] prom_we,
    output logic                              sdram_req,
    output logic [btiger_pkg::SDRAM_AW-1:0]   sdram_addr,
    output btiger_pkg::slot_rsp_t             char_rsp,
    output btiger_pkg::slot_rsp_t             obj_rsp
);

    assign dwnld_busy = downloading;

    cen_gen u_cen (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .cen12  ( pxl2_cen  ),
        .cen6   ( pxl_cen   ),
        .cen3   (           )   // No 3 MHz user in this core
    );

    video_timer #(
        .H_TOTAL    ( H_TOTAL   ),
        .H_VISIBLE  ( H_VISIBLE ),
        .V_TOTAL    ( V_TOTAL   ),
        .V_VISIBLE  ( V_VISIBLE )
    ) u_timer (
        .clk    ( clk       ),
        .reset  ( reset     ),
        .cen6   ( pxl_cen   ),
        .timing ( timing    )
    );

    prom_loader #(
        .PROM_START ( PROM_START )
    ) u_loader (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .prog        ( prog        ),
        .prom_we     ( prom_we     )
    );

    // Char slot gated by vertical blank inside
    rom_fetch_fsm #(
        .CHAR_OFFSET ( CHAR_OFFSET ),
        .OBJ_OFFSET  ( OBJ_OFFSET  )
    ) u_rom (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .lvbl        ( timing.lvbl ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .char_req    ( char_req    ),
        .obj_req     ( obj_req     ),
        .data_read   ( data_read   ),
        .char_rsp    ( char_rsp    ),
        .obj_rsp     ( obj_rsp     ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  )
    );

endmodule

/* verif/tb_btiger_game.sv */
// Small raster only; SDRAM model serves one access at a time and expects the steps to run in order
module tb_btiger_game;

    timeunit 1ns;
    timeprecision 1ps;

    import btiger_pkg::*;

    localparam int          H_TOTAL   = 40;
    localparam int          H_VISIBLE = 24;
    localparam int          V_TOTAL   = 12;
    localparam int          V_VISIBLE = 8;
    localparam logic [21:0] PROM_ST   = 22'h00_8000;
    localparam logic [21:0] CHAR_OFF  = 22'h02_8000;
    localparam logic [21:0] OBJ_OFF   = 22'h0A_0000;

    typedef struct {
        int          kind;      // 0 download, 1 char, 2 obj, 3 both slots, 4 char in blank, 5 raster
        logic [21:0] addr;
        logic [21:0] addr2;     // Obj address for the both-slot step
        logic [7:0]  dat;
        bit          hit;
    } step_t;

    logic          clk, reset, downloading, ioctl_wr, sdram_ack, data_rdy;
    logic [21:0]   ioctl_addr;
    logic [7:0]    ioctl_dout;
    logic [15:0]   data_read;
    slot_req_t     char_req, obj_req;
    logic          pxl2_cen, pxl_cen, dwnld_busy, sdram_req;
    video_timing_t timing;
    prog_bus_t     prog;
    logic [PROM_COUNT-1:0] prom_we;
    logic [SDRAM_AW-1:0]   sdram_addr;
    slot_rsp_t     char_rsp, obj_rsp;

    int     seed = 32'hb66e;
    int     errors, tests, ack_count, req_count, last_grant;
    int     grant_q[$];
    bit     blank_fetch, req_prev, lvbl_prev;
    step_t  steps[$];

    btiger_game #(
        .H_TOTAL(H_TOTAL), .H_VISIBLE(H_VISIBLE), .V_TOTAL(V_TOTAL), .V_VISIBLE(V_VISIBLE),
        .PROM_START(PROM_ST), .CHAR_OFFSET(CHAR_OFF), .OBJ_OFFSET(OBJ_OFF)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bit is_char(input logic [21:0] a);
        return a >= CHAR_OFF && a < CHAR_OFF + 22'(1 << CHAR_AW);
    endfunction

    // Model word is the word address XOR a fixed pattern
    function automatic logic [15:0] model_word(input int slot, input logic [21:0] a);
        logic [21:0] w;
        w = (slot == 1 ? OBJ_OFF : CHAR_OFF) + a;
        return w[15:0] ^ 16'h5a5a;
    endfunction

    function automatic slot_rsp_t rsp_of(input int slot);
        return slot == 1 ? obj_rsp : char_rsp;
    endfunction

    // SDRAM model serving one access at a time
    initial begin
        int  r;
        bit  rd;
        logic [21:0] a;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (!reset && (sdram_req || prog.we)) begin
                rd = sdram_req;
                a  = sdram_addr;
                if (rd) begin
                    req_count++;
                    grant_q.push_back(is_char(a) ? 0 : 1);
                end
                r = $random(seed);
                repeat (1 + r[1:0]) @(posedge clk);
                #1 sdram_ack = 1'b1;
                ack_count++;
                @(posedge clk);
                #1 sdram_ack = 1'b0;
                if (rd) begin
                    @(posedge clk);
                    #1 data_rdy = 1'b1;
                    data_read = a[15:0] ^ 16'h5a5a;
                    @(posedge clk);
                    #1 data_rdy = 1'b0;
                end
            end
        end
    end

    // Flags a char fetch that started from a blanked line
    always @(negedge clk) begin
        if (sdram_req && !req_prev && is_char(sdram_addr) && !lvbl_prev) blank_fetch = 1'b1;
        req_prev  = sdram_req;
        lvbl_prev = timing.lvbl;
    end

    task automatic report_error(input string what);
        $display("%0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_prog(input string name, input prog_bus_t got, input prog_bus_t exp,
                              input bit full);
        if ((full && got !== exp) || (!full && (got.addr !== exp.addr || got.we !== exp.we))) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rom(input string name, input slot_rsp_t got, input slot_rsp_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_timing(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bits(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic download(input logic [21:0] a, input logic [7:0] d);
        prog_bus_t   exp;
        logic [21:0] off;
        int          n0, k;
        exp = '0;
        @(posedge clk);
        #1 downloading = 1'b1;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        n0 = ack_count;
        @(posedge clk);
        #1 ioctl_wr = 1'b0;
        @(negedge clk);
        check_bits("dwnld_busy", 32'(dwnld_busy), 32'd1);
        if (a < PROM_ST) begin
            exp.addr.sdram = a >> 1;
            exp.data       = d;
            exp.mask       = a[0] ? 2'b01 : 2'b10;
            exp.we         = 1'b1;
            check_prog("prog", prog, exp, 1'b1);
            check_bits("prom_we", 32'(prom_we), 32'd0);
            for (k = 0; k < 20 && prog.we; k++) @(negedge clk);
            if (prog.we) report_error("prog_we never dropped after the SDRAM write");
            check_timing("sdram_ack count", ack_count, n0 + 1);
        end else begin
            off = a - PROM_ST;
            exp.addr.prom.sel   = off[10:8];
            exp.addr.prom.index = off[7:0];
            check_prog("prog", prog, exp, 1'b0);
            check_bits("prom_we", 32'(prom_we), 32'(1) << off[10:8]);
            @(negedge clk);
            check_bits("prom_we", 32'(prom_we), 32'd0);
            check_bits("prog_we", 32'(prog.we), 32'd0);
        end
        @(posedge clk);
        #1 downloading = 1'b0;
    endtask

    task automatic read_slot(input int slot, input logic [21:0] a, input bit exp_hit);
        slot_rsp_t exp;
        int        n0, k;
        exp.ok   = 1'b1;
        exp.data = model_word(slot, a);
        n0 = req_count;
        @(posedge clk);
        #1;
        if (slot == 1) obj_req = '{cs: 1'b1, addr: 17'(a)};
        else char_req = '{cs: 1'b1, addr: 17'(a)};
        @(negedge clk);
        if (exp_hit) begin
            check_rom(slot == 1 ? "obj_rsp" : "char_rsp", rsp_of(slot), exp);
            // A miss would have raised the request on the clock just passed
            @(negedge clk);
            check_bits("sdram_req", 32'(sdram_req), 32'd0);
        end else begin
            for (k = 0; k < 4000 && !rsp_of(slot).ok; k++) @(negedge clk);
            if (!rsp_of(slot).ok) report_error("slot miss never returned ok");
            check_rom(slot == 1 ? "obj_rsp" : "char_rsp", rsp_of(slot), exp);
            check_timing("sdram requests", req_count, n0 + 1);
            last_grant = slot;
        end
        @(posedge clk);
        #1 char_req = '0;
        obj_req = '0;
    endtask

    task automatic read_both(input logic [21:0] ca, input logic [21:0] oa);
        slot_rsp_t ce, oe;
        bit        cgot, ogot;
        int        k, first;
        ce = '{ok: 1'b1, data: model_word(0, ca)};
        oe = '{ok: 1'b1, data: model_word(1, oa)};
        first = last_grant == 0 ? 1 : 0;  // Round robin
        for (k = 0; k < 5000 && !(timing.hinit && timing.v == 0); k++) @(negedge clk);
        if (!(timing.hinit && timing.v == 0)) report_error("frame start never seen");
        grant_q.delete();
        @(posedge clk);
        #1 char_req = '{cs: 1'b1, addr: 17'(ca)};
        obj_req = '{cs: 1'b1, addr: 17'(oa)};
        cgot = 1'b0;
        ogot = 1'b0;
        for (k = 0; k < 200 && !(cgot && ogot); k++) begin
            @(negedge clk);
            cgot |= char_rsp.ok;
            ogot |= obj_rsp.ok;
        end
        if (!(cgot && ogot)) report_error("both-slot miss never completed");
        check_rom("char_rsp", char_rsp, ce);
        check_rom("obj_rsp", obj_rsp, oe);
        check_timing("grant count", grant_q.size(), 2);
        if (grant_q.size() == 2) begin
            check_timing("first grant", grant_q[0], first);
            check_timing("second grant", grant_q[1], 1 - first);
            last_grant = grant_q[1];
        end
        @(posedge clk);
        #1 char_req = '0;
        obj_req = '0;
    endtask

    task automatic read_in_blank(input logic [21:0] a);
        int k;
        for (k = 0; k < 5000 && timing.lvbl; k++) @(negedge clk);
        if (timing.lvbl) report_error("vertical blank never started");
        blank_fetch = 1'b0;
        read_slot(0, a, 1'b0);
        check_bits("char fetch in blank", 32'(blank_fetch), 32'd0);
    endtask

    task automatic raster_check();
        int k, p, lines, lhbl_low, hs_high, hs_rise, vs_high, hinits, cen12;
        bit prev_hs;
        lines    = 0;
        lhbl_low = 0;
        hs_high  = 0;
        hs_rise  = 0;
        vs_high  = 0;
        hinits   = 0;
        cen12    = 0;
        prev_hs  = 1'b0;
        for (k = 0; k < 20000 && !(timing.hinit && timing.v == 0); k++) @(negedge clk);
        if (!(timing.hinit && timing.v == 0)) report_error("frame start never seen");
        for (p = 0; p < H_TOTAL * V_TOTAL; p++) begin
            lines    += timing.h == 0;
            lhbl_low += !timing.lhbl;
            hs_high  += timing.hs;
            hs_rise  += timing.hs && !prev_hs && timing.h == (H_VISIBLE + 16) % H_TOTAL;
            vs_high  += timing.vs;
            hinits   += timing.hinit;
            prev_hs   = timing.hs;
            for (k = 0; k < 16 && !pxl_cen; k++) begin
                cen12 += pxl2_cen;
                @(negedge clk);
            end
            if (!pxl_cen) report_error("pixel enable never came");
            cen12 += pxl2_cen;  // The cen6 clock carries a cen12 as well
            @(negedge clk);
        end
        check_timing("lines", lines, V_TOTAL);
        check_timing("lhbl low pixels", lhbl_low, (H_TOTAL - H_VISIBLE) * V_TOTAL);
        check_timing("hs pixels", hs_high, 32 * V_TOTAL);
        check_timing("hs starts", hs_rise, V_TOTAL);
        check_timing("vs pixels", vs_high, 4 * H_TOTAL);
        check_timing("hinit pulses", hinits, V_TOTAL);
        check_timing("pxl2_cen pulses", cen12, 2 * H_TOTAL * V_TOTAL);
    endtask

    initial begin
        int e0;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        char_req    = '0;
        obj_req     = '0;
        errors      = 0;
        tests       = 0;
        ack_count   = 0;
        req_count   = 0;
        last_grant  = 1;
        steps.push_back('{0, 22'h00_0010, 22'h0, 8'ha5, 1'b0});
        steps.push_back('{0, 22'h00_0013, 22'h0, 8'h3c, 1'b0});
        steps.push_back('{0, PROM_ST + 22'h005, 22'h0, 8'h11, 1'b0});
        steps.push_back('{0, PROM_ST + 22'h302, 22'h0, 8'h22, 1'b0});
        steps.push_back('{1, 22'h00_0123, 22'h0, 8'h00, 1'b0});
        steps.push_back('{1, 22'h00_0123, 22'h0, 8'h00, 1'b1});
        steps.push_back('{2, 22'h01_0456, 22'h0, 8'h00, 1'b0});
        steps.push_back('{2, 22'h01_0456, 22'h0, 8'h00, 1'b1});
        steps.push_back('{3, 22'h00_0200, 22'h00_0300, 8'h00, 1'b0});
        steps.push_back('{4, 22'h00_0777, 22'h0, 8'h00, 1'b0});
        steps.push_back('{3, 22'h00_0240, 22'h00_0340, 8'h00, 1'b0});
        steps.push_back('{5, 22'h0, 22'h0, 8'h00, 1'b0});
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_bits("prog_we", 32'(prog.we), 32'd0);
        check_bits("sdram_req", 32'(sdram_req), 32'd0);
        check_bits("prom_we", 32'(prom_we), 32'd0);
        check_bits("dwnld_busy", 32'(dwnld_busy), 32'd0);
        tests++;
        $display("test 0 reset values: %s", errors == 0 ? "ok" : "bad");
        foreach (steps[i]) begin
            e0 = errors;
            case (steps[i].kind)
                0: download(steps[i].addr, steps[i].dat);
                1: read_slot(0, steps[i].addr, steps[i].hit);
                2: read_slot(1, steps[i].addr, steps[i].hit);
                3: read_both(steps[i].addr, steps[i].addr2);
                4: read_in_blank(steps[i].addr);
                default: raster_check();
            endcase
            tests++;
            $display("test %0d kind %0d addr %h: %s", i + 1, steps[i].kind, steps[i].addr,
                     errors == e0 ? "ok" : "bad");
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/btiger_pkg.sv
verilog/cen_gen.sv
verilog/video_timer.sv
verilog/prom_loader.sv
verilog/rom_fetch_fsm.sv
verilog/btiger_game.sv
verif/tb_btiger_game.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_btiger_game
FLIST     ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
